/* Makefile */
TOP := trace_buffer_tb

sim:
	verilator --binary --timing --assert -Wno-fatal -f trace_buffer_top.f \
		--top-module $(TOP) -o $(TOP)_sim
	./obj_dir/$(TOP)_sim > sim.log 2>&1; status=$$?; cat sim.log; \
	if [ $$status -ne 0 ] || grep -q "Testbench failed" sim.log; then exit 1; fi

clean:
	rm -rf obj_dir sim.log

.PHONY: sim clean

/* rtl/trace_buffer_top.sv */
// Trace buffer top: chains capture and store on the trace side and regs on the bus side
`timescale 1ns/1ps
`include "trace_params.svh"

module trace_buffer_top (
    input  logic                 clk,
    input  logic                 rst_b,
    input  logic                 debug_en,
    input  trace_pkg::trace_in_t trace_in,
    input  trace_pkg::reg_req_t  bus_req,
    output trace_pkg::reg_rsp_t  bus_rsp
);

    ////////////////////////////////////////////////////////////
    // Inter-stage links
    ////////////////////////////////////////////////////////////

    // Filtered packet into the buffer
    trace_pkg::capture_t       cap;
    // Buffer state back to the decoder
    trace_pkg::store_status_t  status;
    // Software selected capture mode
    trace_pkg::trace_mode_e    mode;
    // Dword read pointer into the buffer
    logic [`TRACE_DWORD_W-1:0] rd_ptr;

    ////////////////////////////////////////////////////////////
    // Stages
    ////////////////////////////////////////////////////////////

    // Filter and pack
    trace_capture u_capture (
        .clk      (clk),
        .rst_b    (rst_b),
        .trace_in (trace_in),
        .mode     (mode),
        .cap      (cap)
    );

    // Circular buffer
    trace_store u_store (
        .clk    (clk),
        .rst_b  (rst_b),
        .cap    (cap),
        .rd_ptr (rd_ptr),
        .status (status)
    );

    // Debug register access
    trace_regs u_regs (
        .clk      (clk),
        .rst_b    (rst_b),
        .debug_en (debug_en),
        .bus_req  (bus_req),
        .bus_rsp  (bus_rsp),
        .status   (status),
        .mode     (mode),
        .rd_ptr   (rd_ptr)
    );

endmodule

/* rtl/trace_capture.sv */
// First trace stage: filters retired instructions by capture mode and registers one packet
`timescale 1ns/1ps
`include "trace_params.svh"

module trace_capture (
    input  logic                   clk,
    input  logic                   rst_b,
    input  trace_pkg::trace_in_t   trace_in,
    input  trace_pkg::trace_mode_e mode,
    output trace_pkg::capture_t    cap
);

    // Filter decision for the record at this edge
    logic                     keep;
    // Packet built from the raw trace
    trace_pkg::trace_packet_t pkt_next;
    // Registered stage outputs
    logic                     cap_valid_q;
    trace_pkg::trace_packet_t cap_pkt_q;

    ////////////////////////////////////////////////////////////
    // Mode filter
    ////////////////////////////////////////////////////////////

    always_comb begin
        keep = 1'b0;
        case (mode)
            trace_pkg::MODE_ALL: begin
                keep = trace_in.valid;
            end
            // Only traps get through
            trace_pkg::MODE_EXC: begin
                keep = trace_in.valid & (trace_in.exception | trace_in.interrupt);
            end
            // Off, and the undefined encoding
            default: begin
                keep = 1'b0;
            end
        endcase
    end

    ////////////////////////////////////////////////////////////
    // Packet packing
    ////////////////////////////////////////////////////////////

    always_comb begin
        pkt_next           = '0;
        pkt_next.insn      = trace_in.insn;
        pkt_next.address   = trace_in.address;
        pkt_next.tval      = trace_in.tval;
        pkt_next.exception = trace_in.exception;
        pkt_next.ecause    = trace_in.ecause;
        pkt_next.interrupt = trace_in.interrupt;
    end

    // Stage valid
    always_ff @(posedge clk or negedge rst_b) begin
        if (!rst_b) begin
            cap_valid_q <= 1'b0;
        end else begin
            cap_valid_q <= keep;
        end
    end

    // Payload only loads on a kept record
    always_ff @(posedge clk) begin
        if (keep) begin
            cap_pkt_q <= pkt_next;
        end
    end

    assign cap.valid = cap_valid_q;
    assign cap.pkt   = cap_pkt_q;

endmodule

/* rtl/trace_params.svh */
// Buffer geometry and register field widths for the trace buffer, included by RTL and testbench
`ifndef TRACE_PARAMS_SVH
`define TRACE_PARAMS_SVH

////////////////////////////////////////////////////////////
// Buffer geometry
////////////////////////////////////////////////////////////

// Packets held in the buffer, must stay a power of two
`define TRACE_NUM_ENTRIES 16
// Dwords per packet
`define TRACE_PKT_DWORDS 4
// Total buffer depth in dwords
`define TRACE_DEPTH_DWORDS (`TRACE_NUM_ENTRIES * `TRACE_PKT_DWORDS)
// Entry index width, log2 of the entry count
`define TRACE_ENTRY_W 4

////////////////////////////////////////////////////////////
// Field widths
////////////////////////////////////////////////////////////

// Register and trace data word
`define TRACE_DWORD_W 32
// Exception cause field
`define TRACE_ECAUSE_W 5
// Dword offset inside one packet
`define TRACE_DWORD_SEL_W 2

`endif

/* rtl/trace_pkg.sv */
// Shared types for the trace buffer: trace input, packet, stage links and register bus
`include "trace_params.svh"

package trace_pkg;

    ////////////////////////////////////////////////////////////
    // Trace side
    ////////////////////////////////////////////////////////////

    // Retirement trace as the core presents it
    typedef struct packed {
        logic [`TRACE_DWORD_W-1:0]  insn;
        logic [`TRACE_DWORD_W-1:0]  address;
        logic                       valid;
        logic                       exception;
        logic [`TRACE_ECAUSE_W-1:0] ecause;
        logic                       interrupt;
        logic [`TRACE_DWORD_W-1:0]  tval;
    } trace_in_t;

    // Stored packet, declared MSB first so insn lands in dword 0
    // Dword 3 carries exception, ecause and interrupt from bit 0 up
    typedef struct packed {
        logic [`TRACE_DWORD_W-`TRACE_ECAUSE_W-3:0] reserved;
        logic                                      interrupt;
        logic [`TRACE_ECAUSE_W-1:0]                ecause;
        logic                                      exception;
        logic [`TRACE_DWORD_W-1:0]                 tval;
        logic [`TRACE_DWORD_W-1:0]                 address;
        logic [`TRACE_DWORD_W-1:0]                 insn;
    } trace_packet_t;

    // Capture stage output into the store
    typedef struct packed {
        logic          valid;
        trace_packet_t pkt;
    } capture_t;

    // Capture filter, 3 falls through to off
    typedef enum logic [1:0] {
        MODE_OFF = 2'd0,
        MODE_ALL = 2'd1,
        MODE_EXC = 2'd2
    } trace_mode_e;

    ////////////////////////////////////////////////////////////
    // Register side
    ////////////////////////////////////////////////////////////

    // Register index, 6 and 7 left unmapped
    typedef enum logic [2:0] {
        REG_STATUS = 3'd0,
        REG_CONFIG = 3'd1,
        REG_WR_PTR = 3'd2,
        REG_RD_PTR = 3'd3,
        REG_DATA   = 3'd4,
        REG_MODE   = 3'd5
    } reg_addr_e;

    typedef struct packed {
        logic                      req;
        logic                      write;
        reg_addr_e                 addr;
        logic [`TRACE_DWORD_W-1:0] wdata;
    } reg_req_t;

    typedef struct packed {
        logic                      valid;
        logic                      error;
        logic [`TRACE_DWORD_W-1:0] rdata;
    } reg_rsp_t;

    // Store state seen by the register stage
    typedef struct packed {
        logic                      valid_data;
        logic                      wrapped;
        logic [`TRACE_DWORD_W-1:0] wr_ptr;
        logic [`TRACE_DWORD_W-1:0] rd_data;
    } store_status_t;

endpackage

/* rtl/trace_regs.sv */
// Register stage: debug-gated decoder with read pointer, capture mode and registered response
`timescale 1ns/1ps
`include "trace_params.svh"

module trace_regs (
    input  logic                      clk,
    input  logic                      rst_b,
    input  logic                      debug_en,
    input  trace_pkg::reg_req_t       bus_req,
    output trace_pkg::reg_rsp_t       bus_rsp,
    input  trace_pkg::store_status_t  status,
    output trace_pkg::trace_mode_e    mode,
    output logic [`TRACE_DWORD_W-1:0] rd_ptr
);

    // Decode results for the current request
    logic                      rsp_error;
    logic [`TRACE_DWORD_W-1:0] rsp_rdata;
    logic                      rd_ptr_we;
    logic                      mode_we;

    // Software visible state
    logic [`TRACE_DWORD_W-1:0] rd_ptr_q;
    trace_pkg::trace_mode_e    mode_q;

    // Registered response
    logic                      rsp_valid_q;
    logic                      rsp_error_q;
    logic [`TRACE_DWORD_W-1:0] rsp_rdata_q;

    ////////////////////////////////////////////////////////////
    // Address decode
    ////////////////////////////////////////////////////////////

    always_comb begin
        rsp_error = 1'b0;
        rsp_rdata = '0;
        rd_ptr_we = 1'b0;
        mode_we   = 1'b0;
        if (!debug_en) begin
            // Locked out, nothing changes and rdata stays zero
            rsp_error = 1'b1;
        end else if (bus_req.write) begin
            case (bus_req.addr)
                trace_pkg::REG_RD_PTR: begin
                    rd_ptr_we = 1'b1;
                end
                trace_pkg::REG_MODE: begin
                    mode_we = 1'b1;
                end
                // Read-only or unmapped
                default: begin
                    rsp_error = 1'b1;
                end
            endcase
        end else begin
            case (bus_req.addr)
                trace_pkg::REG_STATUS: begin
                    rsp_rdata[1:0] = {status.wrapped, status.valid_data};
                end
                trace_pkg::REG_CONFIG: begin
                    rsp_rdata = `TRACE_DWORD_W'(`TRACE_DEPTH_DWORDS);
                end
                trace_pkg::REG_WR_PTR: begin
                    rsp_rdata = status.wr_ptr;
                end
                trace_pkg::REG_RD_PTR: begin
                    rsp_rdata = rd_ptr_q;
                end
                // Dword at the read pointer, straight from the store
                trace_pkg::REG_DATA: begin
                    rsp_rdata = status.rd_data;
                end
                trace_pkg::REG_MODE: begin
                    rsp_rdata[1:0] = mode_q;
                end
                // Indices 6 and 7
                default: begin
                    rsp_error = 1'b1;
                end
            endcase
        end
    end

    ////////////////////////////////////////////////////////////
    // Read pointer and mode
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge rst_b) begin
        if (!rst_b) begin
            rd_ptr_q <= '0;
            mode_q   <= trace_pkg::MODE_ALL;
        end else if (bus_req.req) begin
            if (rd_ptr_we) begin
                rd_ptr_q <= bus_req.wdata;
            end
            // Mode applies to trace sampled from the next edge on
            if (mode_we) begin
                mode_q <= trace_pkg::trace_mode_e'(bus_req.wdata[1:0]);
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // Response
    ////////////////////////////////////////////////////////////

    // One-cycle valid after each strobe
    always_ff @(posedge clk or negedge rst_b) begin
        if (!rst_b) begin
            rsp_valid_q <= 1'b0;
        end else begin
            rsp_valid_q <= bus_req.req;
        end
    end

    // Payload held between requests
    always_ff @(posedge clk) begin
        if (bus_req.req) begin
            rsp_error_q <= rsp_error;
            rsp_rdata_q <= rsp_rdata;
        end
    end

    always_comb begin
        bus_rsp.valid = rsp_valid_q;
        bus_rsp.error = rsp_error_q;
        bus_rsp.rdata = rsp_rdata_q;
    end

    assign mode   = mode_q;
    assign rd_ptr = rd_ptr_q;

endmodule

/* rtl/trace_store.sv */
// Second trace stage: circular packet buffer with write pointer, flags and a dword read port
`timescale 1ns/1ps
`include "trace_params.svh"

module trace_store (
    input  logic                      clk,
    input  logic                      rst_b,
    input  trace_pkg::capture_t       cap,
    input  logic [`TRACE_DWORD_W-1:0] rd_ptr,
    output trace_pkg::store_status_t  status
);

    // Packet storage
    trace_pkg::trace_packet_t mem [`TRACE_NUM_ENTRIES];

    // Dword write pointer and sticky flags
    logic [`TRACE_DWORD_W-1:0] wr_ptr_q;
    logic [`TRACE_DWORD_W-1:0] wr_ptr_sum;
    logic                      valid_data_q;
    logic                      wrapped_q;

    // Entry indices derived from the dword pointers
    logic [`TRACE_ENTRY_W-1:0]     wr_entry;
    logic [`TRACE_ENTRY_W-1:0]     rd_entry;
    logic [`TRACE_DWORD_SEL_W-1:0] rd_dword;

    // Selected packet and dword on the read side
    trace_pkg::trace_packet_t  rd_pkt;
    logic [`TRACE_DWORD_W-1:0] rd_data;

    ////////////////////////////////////////////////////////////
    // Write pointer
    ////////////////////////////////////////////////////////////

    // Pointer steps one packet at a time
    assign wr_ptr_sum = wr_ptr_q + `TRACE_DWORD_W'(`TRACE_PKT_DWORDS);

    // Packet slot is the dword pointer over four
    assign wr_entry = wr_ptr_q[`TRACE_DWORD_SEL_W +: `TRACE_ENTRY_W];

    always_ff @(posedge clk or negedge rst_b) begin
        if (!rst_b) begin
            wr_ptr_q     <= '0;
            valid_data_q <= 1'b0;
            wrapped_q    <= 1'b0;
        end else if (cap.valid) begin
            valid_data_q <= 1'b1;
            // Roll over at the end of the buffer
            if (wr_ptr_sum >= `TRACE_DWORD_W'(`TRACE_DEPTH_DWORDS)) begin
                wr_ptr_q  <= '0;
                wrapped_q <= 1'b1;
            end else begin
                wr_ptr_q <= wr_ptr_sum;
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // Packet array
    ////////////////////////////////////////////////////////////

    // Write port, separate from the read port below
    always_ff @(posedge clk) begin
        if (cap.valid) begin
            mem[wr_entry] <= cap.pkt;
        end
    end

    ////////////////////////////////////////////////////////////
    // Read port
    ////////////////////////////////////////////////////////////

    // Low two bits pick the dword
    assign rd_dword = rd_ptr[`TRACE_DWORD_SEL_W-1:0];

    // Upper bits wrap modulo the entry count
    assign rd_entry = rd_ptr[`TRACE_DWORD_SEL_W +: `TRACE_ENTRY_W];

    assign rd_pkt  = mem[rd_entry];
    assign rd_data = rd_pkt[rd_dword * `TRACE_DWORD_W +: `TRACE_DWORD_W];

    ////////////////////////////////////////////////////////////
    // Status to register stage
    ////////////////////////////////////////////////////////////

    always_comb begin
        status.valid_data = valid_data_q;
        status.wrapped    = wrapped_q;
        status.wr_ptr     = wr_ptr_q;
        status.rd_data    = rd_data;
    end

endmodule

/* trace_buffer_top.f */
+incdir+rtl
rtl/trace_pkg.sv
rtl/trace_capture.sv
rtl/trace_store.sv
rtl/trace_regs.sv
rtl/trace_buffer_top.sv
verif/trace_buffer_asserts.sv
verif/trace_buffer_checker.sv
verif/trace_buffer_tb.sv

/* verif/trace_buffer_asserts.sv */
// Concurrent checks on the register handshake, reset and store flags, bound into the top level
`timescale 1ns/1ps
`include "trace_params.svh"

module trace_buffer_asserts (
    input logic                     clk,
    input logic                     rst_b,
    input trace_pkg::reg_req_t      bus_req,
    input trace_pkg::reg_rsp_t      bus_rsp,
    input trace_pkg::store_status_t status
);

    // Every strobe answered at the next edge
    assert property (@(posedge clk) disable iff (!rst_b) bus_req.req |=> bus_rsp.valid)
        else $error("register request not answered one cycle later");

    // No response without a request one cycle earlier
    assert property (@(posedge clk) disable iff (!rst_b) bus_rsp.valid |-> $past(bus_req.req))
        else $error("register response without a request");

    // Response held off during reset
    assert property (@(posedge clk) !rst_b |-> !bus_rsp.valid)
        else $error("register response valid during reset");

    // Sticky wrap flag
    assert property (@(posedge clk) disable iff (!rst_b) $past(status.wrapped) |-> status.wrapped)
        else $error("wrapped flag cleared outside reset");

    // Packet aligned and inside the buffer
    assert property (@(posedge clk) disable iff (!rst_b)
        (status.wr_ptr[1:0] == 2'b00) && (status.wr_ptr < `TRACE_DEPTH_DWORDS))
        else $error("write pointer out of range or unaligned");

endmodule

bind trace_buffer_top trace_buffer_asserts u_asserts (
    .clk     (clk),
    .rst_b   (rst_b),
    .bus_req (bus_req),
    .bus_rsp (bus_rsp),
    .status  (status)
);

/* verif/trace_buffer_checker.sv */
// Reference model of the trace buffer that the testbench top instantiates to compare every response
`timescale 1ns/1ps
`include "trace_params.svh"

module trace_buffer_checker (
    input  logic                 clk,
    input  logic                 rst_b,
    input  logic                 debug_en,
    input  trace_pkg::trace_in_t trace_in,
    input  trace_pkg::reg_req_t  bus_req,
    input  trace_pkg::reg_rsp_t  bus_rsp,
    input  logic                 test_end,
    input  logic                 all_done,
    output int                   error_count
);

    // Model of the software visible state
    logic [1:0]   m_mode;
    logic [31:0]  m_rd_ptr;
    logic [31:0]  m_wr_ptr;
    logic         m_valid_data;
    logic         m_wrapped;
    logic [127:0] m_mem [`TRACE_NUM_ENTRIES];

    // Packet in flight between capture and store
    logic         cap_pend;
    logic [127:0] cap_pkt;

    // Response owed at the next edge
    logic                rsp_pend;
    logic [2:0]          rsp_addr;
    trace_pkg::reg_rsp_t rsp_exp;

    int test_num;
    int test_checks;
    int test_errors;
    int total_checks;

    ////////////////////////////////////////////////////////////
    // Reference rules
    ////////////////////////////////////////////////////////////

    // Mode filter where 3 counts as off
    function automatic logic record_kept(input trace_pkg::trace_in_t t, input logic [1:0] md);
        if (md == 2'd1) begin
            return t.valid;
        end
        if (md == 2'd2) begin
            return t.valid & (t.exception | t.interrupt);
        end
        return 1'b0;
    endfunction

    // Dwords 0 to 2 carry insn, address and tval
    // Dword 3 holds the trap bits from bit 0 up
    function automatic logic [127:0] pack_record(input trace_pkg::trace_in_t t);
        return {25'd0, t.interrupt, t.ecause, t.exception, t.tval, t.address, t.insn};
    endfunction

    // Expected response from the model state before this edge
    function automatic trace_pkg::reg_rsp_t expected_rsp(input trace_pkg::reg_req_t req,
                                                         input logic en);
        trace_pkg::reg_rsp_t r;
        logic [127:0]        pkt;
        int                  sel;
        r.valid = 1'b1;
        r.error = 1'b0;
        r.rdata = '0;
        pkt     = m_mem[(m_rd_ptr / 4) % `TRACE_NUM_ENTRIES];
        sel     = int'(m_rd_ptr[1:0]);
        if (!en) begin
            r.error = 1'b1;
        end else if (req.write) begin
            // Only the read pointer and mode are writable
            r.error = !(req.addr == trace_pkg::REG_RD_PTR || req.addr == trace_pkg::REG_MODE);
        end else begin
            case (req.addr)
                trace_pkg::REG_STATUS: r.rdata = {30'd0, m_wrapped, m_valid_data};
                trace_pkg::REG_CONFIG: r.rdata = `TRACE_DEPTH_DWORDS;
                trace_pkg::REG_WR_PTR: r.rdata = m_wr_ptr;
                trace_pkg::REG_RD_PTR: r.rdata = m_rd_ptr;
                trace_pkg::REG_DATA:   r.rdata = pkt[sel*32 +: 32];
                trace_pkg::REG_MODE:   r.rdata = {30'd0, m_mode};
                default:               r.error = 1'b1;
            endcase
        end
        return r;
    endfunction

    ////////////////////////////////////////////////////////////
    // Compare and model update, once per edge
    ////////////////////////////////////////////////////////////

    always @(posedge clk) begin
        if (!rst_b) begin
            m_mode       = 2'd1;
            m_rd_ptr     = '0;
            m_wr_ptr     = '0;
            m_valid_data = 1'b0;
            m_wrapped    = 1'b0;
            cap_pend     = 1'b0;
            rsp_pend     = 1'b0;
            error_count  = 0;
            test_num     = 1;
            test_checks  = 0;
            test_errors  = 0;
            total_checks = 0;
        end else begin
            // Response launched by the previous edge
            if (rsp_pend) begin
                test_checks++;
                total_checks++;
                if (!bus_rsp.valid) begin
                    $display("Register %0d request got no response at time %0t",
                             rsp_addr, $time);
                    test_errors++;
                    error_count++;
                end else if (bus_rsp.error !== rsp_exp.error ||
                             bus_rsp.rdata !== rsp_exp.rdata) begin
                    $display({"FAILED time %0t: register %0d expected error %0b rdata 0x%08h,",
                              " got error %0b rdata 0x%08h"},
                             $time, rsp_addr, rsp_exp.error, rsp_exp.rdata,
                             bus_rsp.error, bus_rsp.rdata);
                    test_errors++;
                    error_count++;
                end
            end else if (bus_rsp.valid) begin
                $display("Register response appeared without a request at time %0t", $time);
                test_errors++;
                error_count++;
            end
            rsp_pend = bus_req.req;
            if (bus_req.req) begin
                rsp_exp  = expected_rsp(bus_req, debug_en);
                rsp_addr = bus_req.addr;
            end
            // Store writes the packet captured one edge ago
            if (cap_pend) begin
                m_mem[(m_wr_ptr / 4) % `TRACE_NUM_ENTRIES] = cap_pkt;
                m_valid_data = 1'b1;
                if (m_wr_ptr + 4 >= `TRACE_DEPTH_DWORDS) begin
                    m_wr_ptr  = '0;
                    m_wrapped = 1'b1;
                end else begin
                    m_wr_ptr = m_wr_ptr + 4;
                end
            end
            // Capture uses the mode in force before any write at this edge
            cap_pend = record_kept(trace_in, m_mode);
            if (cap_pend) begin
                cap_pkt = pack_record(trace_in);
            end
            if (bus_req.req && debug_en && bus_req.write) begin
                if (bus_req.addr == trace_pkg::REG_RD_PTR) begin
                    m_rd_ptr = bus_req.wdata;
                end
                if (bus_req.addr == trace_pkg::REG_MODE) begin
                    m_mode = bus_req.wdata[1:0];
                end
            end
            if (test_end) begin
                $display("Test %0d finished: %0d checks, %0d errors",
                         test_num, test_checks, test_errors);
                test_num++;
                test_checks = 0;
                test_errors = 0;
            end
            if (all_done) begin
                $display("Totals: %0d tests, %0d checks, %0d errors",
                         test_num - 1, total_checks, error_count);
            end
        end
    end

endmodule

/* verif/trace_buffer_tb.sv */
// Simulation top that drives clock, reset, random trace records and register accesses into the trace buffer
`timescale 1ns/1ps
`include "trace_params.svh"

module trace_buffer_tb;

    localparam int RSP_TIMEOUT = 20;

    logic                 clk = 1'b0;
    logic                 rst_b;
    logic                 debug_en;
    logic                 test_end;
    logic                 all_done;
    trace_pkg::trace_in_t trace_in;
    trace_pkg::reg_req_t  bus_req;
    trace_pkg::reg_rsp_t  bus_rsp;
    int                   error_count;
    int                   timeouts;
    logic [31:0]          lcg_state;

    // 4 ns period
    always #2 clk = ~clk;

    trace_buffer_top uut (
        .clk      (clk),
        .rst_b    (rst_b),
        .debug_en (debug_en),
        .trace_in (trace_in),
        .bus_req  (bus_req),
        .bus_rsp  (bus_rsp)
    );

    trace_buffer_checker u_checker (
        .clk         (clk),
        .rst_b       (rst_b),
        .debug_en    (debug_en),
        .trace_in    (trace_in),
        .bus_req     (bus_req),
        .bus_rsp     (bus_rsp),
        .test_end    (test_end),
        .all_done    (all_done),
        .error_count (error_count)
    );

    ////////////////////////////////////////////////////////////
    // Stimulus helpers
    ////////////////////////////////////////////////////////////

    // LCG step
    function automatic logic [31:0] next_random();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state;
    endfunction

    // Retired instruction with occasional traps
    function automatic trace_pkg::trace_in_t random_record();
        trace_pkg::trace_in_t t;
        logic [31:0]          bits;
        t.insn      = next_random();
        t.address   = next_random() & 32'hffff_fffc;
        t.tval      = next_random();
        bits        = next_random();
        t.valid     = 1'b1;
        t.exception = bits[20] & bits[21];
        t.interrupt = bits[22] & bits[23] & bits[24];
        t.ecause    = bits[12:8];
        return t;
    endfunction

    // One register access that waits for its response
    task automatic bus_op(input logic write, input logic [2:0] addr, input logic [31:0] wdata);
        trace_pkg::reg_req_t r;
        int                  waited;
        r.req   = 1'b1;
        r.write = write;
        r.addr  = trace_pkg::reg_addr_e'(addr);
        r.wdata = wdata;
        @(posedge clk);
        bus_req <= r;
        @(posedge clk);
        bus_req.req <= 1'b0;
        waited = 0;
        while (!bus_rsp.valid && waited < RSP_TIMEOUT) begin
            @(posedge clk);
            waited++;
        end
        if (!bus_rsp.valid) begin
            $display("Timeout: register %0d got no response within %0d cycles", addr, waited);
            timeouts++;
        end
    endtask

    // Records with random idle gaps between them
    task automatic push_records(input int count);
        int gap;
        for (int i = 0; i < count; i++) begin
            @(posedge clk);
            trace_in <= random_record();
            gap = int'(next_random() % 3);
            for (int g = 0; g < gap; g++) begin
                @(posedge clk);
                trace_in.valid <= 1'b0;
            end
        end
        @(posedge clk);
        trace_in.valid <= 1'b0;
        // Let the last packet reach the store
        repeat (3) @(posedge clk);
    endtask

    // Walk the buffer dword by dword through RD_PTR and DATA
    task automatic read_dwords(input int count);
        for (int i = 0; i < count; i++) begin
            bus_op(1'b1, trace_pkg::REG_RD_PTR, i);
            bus_op(1'b0, trace_pkg::REG_DATA, '0);
        end
    endtask

    task automatic finish_test();
        @(posedge clk);
        test_end <= 1'b1;
        @(posedge clk);
        test_end <= 1'b0;
    endtask

    ////////////////////////////////////////////////////////////
    // Sequences
    ////////////////////////////////////////////////////////////

    initial begin
        rst_b     <= 1'b0;
        debug_en  <= 1'b1;
        test_end  <= 1'b0;
        all_done  <= 1'b0;
        trace_in  <= '0;
        bus_req   <= '0;
        lcg_state = 32'd99026;
        timeouts  = 0;
        repeat (5) @(posedge clk);
        rst_b <= 1'b1;

        // Reset values
        bus_op(1'b0, trace_pkg::REG_STATUS, '0);
        bus_op(1'b0, trace_pkg::REG_CONFIG, '0);
        bus_op(1'b0, trace_pkg::REG_WR_PTR, '0);
        bus_op(1'b0, trace_pkg::REG_MODE, '0);
        finish_test();

        // Ten records, no wrap yet
        push_records(10);
        bus_op(1'b0, trace_pkg::REG_WR_PTR, '0);
        bus_op(1'b0, trace_pkg::REG_STATUS, '0);
        read_dwords(40);
        finish_test();

        // Twenty more wrap the buffer
        push_records(20);
        bus_op(1'b0, trace_pkg::REG_STATUS, '0);
        bus_op(1'b0, trace_pkg::REG_WR_PTR, '0);
        read_dwords(56);
        finish_test();

        // Trap-only capture followed by capture off
        bus_op(1'b1, trace_pkg::REG_MODE, 32'd2);
        push_records(12);
        bus_op(1'b0, trace_pkg::REG_WR_PTR, '0);
        read_dwords(`TRACE_DEPTH_DWORDS);
        bus_op(1'b1, trace_pkg::REG_MODE, 32'd0);
        push_records(5);
        bus_op(1'b0, trace_pkg::REG_WR_PTR, '0);
        finish_test();

        // Debug gating and illegal accesses
        @(posedge clk);
        debug_en <= 1'b0;
        for (int a = 0; a < 8; a++) begin
            bus_op(1'b0, a[2:0], '0);
        end
        bus_op(1'b1, trace_pkg::REG_RD_PTR, 32'h15);
        bus_op(1'b1, trace_pkg::REG_MODE, 32'd1);
        @(posedge clk);
        debug_en <= 1'b1;
        bus_op(1'b0, trace_pkg::REG_RD_PTR, '0);
        bus_op(1'b0, trace_pkg::REG_MODE, '0);
        bus_op(1'b1, trace_pkg::REG_STATUS, 32'd1);
        bus_op(1'b1, trace_pkg::REG_CONFIG, 32'd1);
        bus_op(1'b1, trace_pkg::REG_WR_PTR, 32'd1);
        bus_op(1'b1, trace_pkg::REG_DATA, 32'd1);
        bus_op(1'b0, 3'd6, '0);
        bus_op(1'b1, 3'd6, 32'd1);
        bus_op(1'b0, 3'd7, '0);
        bus_op(1'b1, 3'd7, 32'd1);
        finish_test();

        // Closing counts from the checker and the verdict
        @(posedge clk);
        all_done <= 1'b1;
        @(posedge clk);
        all_done <= 1'b0;
        repeat (2) @(posedge clk);
        if (error_count == 0 && timeouts == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule
